/* rtl/prefetch_pkg.sv */
package prefetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W         = 32;
  localparam int LINE_W         = 128;
  localparam int INSTR_W        = 32;
  localparam int HALF_W         = 16;
  localparam int WORDS_PER_LINE = LINE_W / INSTR_W;
  localparam int LINE_OFFSET_W  = 4;
  localparam int LINE_BYTES     = LINE_W / 8;

  // low opcode bits of an uncompressed instruction
  localparam logic [1:0] OPCODE_FULL = 2'b11;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [LINE_W-1:0]  line_t;
  typedef logic [INSTR_W-1:0] instr_t;
  typedef logic [HALF_W-1:0]  half_t;

  //////////////////////////////////////////////////////////////////////
  // aligner FSM
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    IDLE, BRANCHED,
    NOT_VALID, NOT_VALID_GRANTED,
    NOT_VALID_CROSS, NOT_VALID_CROSS_GRANTED,
    VALID, VALID_CROSS, VALID_GRANTED, VALID_FETCH_DONE
  } aligner_state_e;

endpackage

/* rtl/line_fetch_if.sv */
interface line_fetch_if;

  // aligner side requests
  logic                prefetch_req;
  prefetch_pkg::addr_t prefetch_addr;
  logic                branch;
  prefetch_pkg::addr_t branch_addr;

  // line buffer answers
  logic                fetch_gnt;
  logic                fetch_valid;
  prefetch_pkg::line_t line;
  prefetch_pkg::addr_t line_addr;
  logic                line_valid;

  modport buf_mp (
    input  prefetch_req, prefetch_addr, branch, branch_addr,
    output fetch_gnt, fetch_valid, line, line_addr, line_valid
  );

  modport align_mp (
    output prefetch_req, prefetch_addr, branch, branch_addr,
    input  fetch_gnt, fetch_valid, line, line_addr, line_valid
  );

endinterface

/* rtl/l0_line_buffer.sv */
module l0_line_buffer (
  input  logic                clk,
  input  logic                rst_n,
  line_fetch_if.buf_mp        fetch,
  output logic                instr_req_o,
  output prefetch_pkg::addr_t instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  prefetch_pkg::line_t instr_rdata_i,
  output logic                busy_o
);

  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_WAIT_GNT,
    REQ_WAIT_RVALID
  } req_state_e;

  req_state_e          req_state_q;
  prefetch_pkg::addr_t req_addr_q;
  prefetch_pkg::addr_t pend_addr_q;
  prefetch_pkg::addr_t start_addr;
  prefetch_pkg::addr_t line_addr_q;
  prefetch_pkg::line_t line_q;
  logic                req_pf_q;
  logic                drop_q;
  logic                pend_q;
  logic                line_valid_q;
  logic                fetch_valid_q;
  logic                start_req;
  logic                start_pf;
  logic                resp_done;
  logic                resp_take;

  function automatic prefetch_pkg::addr_t line_base(input prefetch_pkg::addr_t a);
    return {a[prefetch_pkg::ADDR_W-1:prefetch_pkg::LINE_OFFSET_W],
            {prefetch_pkg::LINE_OFFSET_W{1'b0}}};
  endfunction

  // new request, branch first, then a deferred branch, then prefetch
  always_comb begin
    start_req  = 1'b0;
    start_pf   = 1'b0;
    start_addr = pend_addr_q;
    if (req_state_q == REQ_IDLE) begin
      if (fetch.branch) begin
        start_req  = 1'b1;
        start_addr = line_base(fetch.branch_addr);
      end else if (pend_q) begin
        start_req = 1'b1;
      end else if (fetch.prefetch_req) begin
        start_req  = 1'b1;
        start_pf   = 1'b1;
        start_addr = line_base(fetch.prefetch_addr);
      end
    end
  end

  // response may come together with the grant
  assign resp_done = instr_rvalid_i &&
                     ((req_state_q == REQ_WAIT_RVALID) ||
                      (req_state_q == REQ_WAIT_GNT && instr_gnt_i));
  assign resp_take = resp_done && !drop_q && !fetch.branch;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_state_q   <= REQ_IDLE;
      req_pf_q      <= 1'b0;
      drop_q        <= 1'b0;
      pend_q        <= 1'b0;
      line_valid_q  <= 1'b0;
      fetch_valid_q <= 1'b0;
    end else begin
      fetch_valid_q <= resp_take;
      case (req_state_q)
        REQ_IDLE: begin
          if (start_req) begin
            req_state_q <= REQ_WAIT_GNT;
            req_pf_q    <= start_pf;
            pend_q      <= 1'b0;
          end
        end
        REQ_WAIT_GNT: begin
          if (instr_gnt_i) begin
            req_state_q <= instr_rvalid_i ? REQ_IDLE : REQ_WAIT_RVALID;
          end
        end
        REQ_WAIT_RVALID: begin
          if (instr_rvalid_i) begin
            req_state_q <= REQ_IDLE;
          end
        end
        default: req_state_q <= REQ_IDLE;
      endcase
      if (resp_done) begin
        drop_q <= 1'b0;
      end
      // branch over a request in flight, its line is stale
      if (fetch.branch && req_state_q != REQ_IDLE) begin
        pend_q <= 1'b1;
        if (!resp_done) begin
          drop_q <= 1'b1;
        end
      end
      if (fetch.branch) begin
        line_valid_q <= 1'b0;
      end else if (resp_take) begin
        line_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_req) begin
      req_addr_q <= start_addr;
    end
    if (fetch.branch) begin
      pend_addr_q <= line_base(fetch.branch_addr);
    end
    if (resp_take) begin
      line_q      <= instr_rdata_i;
      line_addr_q <= req_addr_q;
    end
  end

  assign instr_req_o       = (req_state_q == REQ_WAIT_GNT);
  assign instr_addr_o      = req_addr_q;
  assign busy_o            = (req_state_q != REQ_IDLE);
  // only a live prefetch grant is reported
  assign fetch.fetch_gnt   = instr_gnt_i && instr_req_o && req_pf_q && !drop_q;
  assign fetch.fetch_valid = fetch_valid_q;
  assign fetch.line        = line_q;
  assign fetch.line_addr   = line_addr_q;
  assign fetch.line_valid  = line_valid_q;

  a_req_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instr_addr_o changed before grant");

  a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> req_state_q != REQ_IDLE)
    else $error("instr_rvalid_i without outstanding request");

endmodule

/* rtl/instr_aligner.sv */
module instr_aligner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 branch_i,
  input  prefetch_pkg::addr_t  addr_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output prefetch_pkg::instr_t rdata_o,
  output prefetch_pkg::addr_t  addr_o,
  line_fetch_if.align_mp       fetch
);

  prefetch_pkg::aligner_state_e state_q;
  prefetch_pkg::aligner_state_e state_n;
  prefetch_pkg::addr_t          addr_q;
  prefetch_pkg::addr_t          addr_n;
  prefetch_pkg::addr_t          addr_step;
  prefetch_pkg::addr_t          line_base;
  prefetch_pkg::instr_t         last_q;
  prefetch_pkg::instr_t [prefetch_pkg::WORDS_PER_LINE-1:0] line_words;
  prefetch_pkg::instr_t         cur_word;
  prefetch_pkg::instr_t         w3_word;
  prefetch_pkg::half_t          hi_half;
  prefetch_pkg::half_t          lo_half;
  logic [1:0]                   next_word_idx;
  logic                         use_last;
  logic                         valid;
  logic                         do_fetch;
  logic                         save_last;
  logic                         xfer;
  logic                         line_hit;
  logic                         in_word3;
  logic                         leaves_line;
  logic                         aligned_comp;
  logic                         unaligned_comp;
  logic                         upper_comp;
  logic                         is_full;
  logic                         is_crossword;
  logic                         next_is_crossword;

  //////////////////////////////////////////////////////////////////////
  // instruction decode
  //////////////////////////////////////////////////////////////////////

  assign line_words = fetch.line;

  // word 3 comes from the saved copy once the next line is requested
  assign use_last = (state_q == prefetch_pkg::VALID_CROSS) ||
                    (state_q == prefetch_pkg::VALID_GRANTED) ||
                    (state_q == prefetch_pkg::VALID_FETCH_DONE) ||
                    (state_q == prefetch_pkg::NOT_VALID_CROSS_GRANTED);

  assign next_word_idx = addr_q[3:2] + 2'd1;
  assign cur_word      = use_last ? last_q : line_words[addr_q[3:2]];
  assign w3_word       = use_last ? last_q : line_words[prefetch_pkg::WORDS_PER_LINE-1];

  assign aligned_comp   = cur_word[1:0] != prefetch_pkg::OPCODE_FULL;
  assign unaligned_comp = cur_word[17:16] != prefetch_pkg::OPCODE_FULL;
  assign upper_comp     = w3_word[17:16] != prefetch_pkg::OPCODE_FULL;
  assign is_full        = addr_q[1] ? !unaligned_comp : !aligned_comp;

  assign is_crossword      = (addr_q[3:1] == 3'b111) && !upper_comp;
  assign next_is_crossword = ((addr_q[3:1] == 3'b110) && aligned_comp && !upper_comp) ||
                             ((addr_q[3:1] == 3'b101) && !unaligned_comp && !upper_comp);

  assign in_word3  = (addr_q[3:2] == 2'b11);
  assign addr_step = addr_q + (is_full ? prefetch_pkg::addr_t'(4) : prefetch_pkg::addr_t'(2));
  assign leaves_line =
    addr_step[prefetch_pkg::ADDR_W-1:prefetch_pkg::LINE_OFFSET_W] !=
    addr_q[prefetch_pkg::ADDR_W-1:prefetch_pkg::LINE_OFFSET_W];
  assign line_base = {addr_q[prefetch_pkg::ADDR_W-1:prefetch_pkg::LINE_OFFSET_W],
                      {prefetch_pkg::LINE_OFFSET_W{1'b0}}};
  assign line_hit  = fetch.line_valid &&
    (fetch.line_addr[prefetch_pkg::ADDR_W-1:prefetch_pkg::LINE_OFFSET_W] ==
     addr_q[prefetch_pkg::ADDR_W-1:prefetch_pkg::LINE_OFFSET_W]);

  // output valid per state
  always_comb begin
    case (state_q)
      prefetch_pkg::VALID:            valid = line_hit && !is_crossword;
      prefetch_pkg::VALID_GRANTED:    valid = !is_crossword;
      prefetch_pkg::VALID_CROSS:      valid = 1'b1;
      prefetch_pkg::VALID_FETCH_DONE: valid = 1'b1;
      default:                        valid = 1'b0;
    endcase
  end

  assign valid_o = valid && !branch_i;
  assign xfer    = valid_o && ready_i;

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n   = state_q;
    addr_n    = xfer ? addr_step : addr_q;
    do_fetch  = 1'b0;
    save_last = 1'b0;
    case (state_q)
      prefetch_pkg::IDLE: begin
        // nothing until the first branch
      end
      prefetch_pkg::BRANCHED: begin
        if (fetch.fetch_valid) state_n = prefetch_pkg::VALID;
      end
      prefetch_pkg::NOT_VALID: begin
        do_fetch = 1'b1;
        if (fetch.fetch_gnt) state_n = prefetch_pkg::NOT_VALID_GRANTED;
      end
      prefetch_pkg::NOT_VALID_GRANTED: begin
        if (fetch.fetch_valid) state_n = prefetch_pkg::VALID;
      end
      prefetch_pkg::NOT_VALID_CROSS: begin
        do_fetch = 1'b1;
        if (fetch.fetch_gnt) begin
          save_last = 1'b1;
          state_n   = prefetch_pkg::NOT_VALID_CROSS_GRANTED;
        end
      end
      prefetch_pkg::NOT_VALID_CROSS_GRANTED: begin
        if (fetch.fetch_valid) state_n = prefetch_pkg::VALID_CROSS;
      end
      prefetch_pkg::VALID: begin
        do_fetch = in_word3;
        if (fetch.fetch_gnt) begin
          // line is still current here, keep its word 3
          save_last = 1'b1;
          if (xfer && leaves_line) state_n = prefetch_pkg::NOT_VALID_GRANTED;
          else if (xfer ? next_is_crossword : is_crossword)
            state_n = prefetch_pkg::NOT_VALID_CROSS_GRANTED;
          else state_n = prefetch_pkg::VALID_GRANTED;
        end else if (is_crossword) begin
          state_n = prefetch_pkg::NOT_VALID_CROSS;
        end else if (xfer) begin
          if (leaves_line) state_n = prefetch_pkg::NOT_VALID;
          else if (next_is_crossword) state_n = prefetch_pkg::NOT_VALID_CROSS;
        end
      end
      prefetch_pkg::VALID_CROSS: begin
        if (xfer) state_n = prefetch_pkg::VALID;
      end
      prefetch_pkg::VALID_GRANTED: begin
        if (is_crossword) begin
          state_n = fetch.fetch_valid ? prefetch_pkg::VALID_CROSS
                                      : prefetch_pkg::NOT_VALID_CROSS_GRANTED;
        end else if (xfer && leaves_line) begin
          state_n = fetch.fetch_valid ? prefetch_pkg::VALID : prefetch_pkg::NOT_VALID_GRANTED;
        end else if (fetch.fetch_valid) begin
          state_n = prefetch_pkg::VALID_FETCH_DONE;
        end
      end
      prefetch_pkg::VALID_FETCH_DONE: begin
        if (xfer && leaves_line) state_n = prefetch_pkg::VALID;
      end
      default: state_n = prefetch_pkg::IDLE;
    endcase

    // branches always win
    if (branch_i) begin
      addr_n  = addr_i;
      state_n = (state_q == prefetch_pkg::IDLE && !req_i) ? prefetch_pkg::IDLE
                                                           : prefetch_pkg::BRANCHED;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= prefetch_pkg::IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_n;
      addr_q  <= addr_n;
    end
  end

  always_ff @(posedge clk) begin
    if (save_last) last_q <= line_words[prefetch_pkg::WORDS_PER_LINE-1];
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  // unaligned upper half comes from the next word, wrapping into the next line
  assign lo_half = addr_q[1] ? cur_word[31:16] : cur_word[15:0];
  assign hi_half = addr_q[1] ? line_words[next_word_idx][15:0] : cur_word[31:16];
  assign rdata_o = is_full ? {hi_half, lo_half} : {16'h0000, lo_half};
  assign addr_o  = addr_q;

  assign fetch.prefetch_req  = do_fetch;
  assign fetch.prefetch_addr = in_word3 ? line_base + prefetch_pkg::addr_t'(prefetch_pkg::LINE_BYTES)
                                        : line_base;
  assign fetch.branch        = branch_i;
  assign fetch.branch_addr   = addr_i;

  a_branch_kills_valid: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |-> !valid_o ##1 !valid_o)
    else $error("valid_o raised across a branch");

  a_crossword_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(is_crossword && next_is_crossword))
    else $error("crossword and next crossword at once");

endmodule

/* rtl/prefetch_l0_top.sv */
module prefetch_l0_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 branch_i,
  input  prefetch_pkg::addr_t  addr_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output prefetch_pkg::instr_t rdata_o,
  output prefetch_pkg::addr_t  addr_o,
  output logic                 instr_req_o,
  output prefetch_pkg::addr_t  instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  prefetch_pkg::line_t  instr_rdata_i,
  output logic                 busy_o
);

  line_fetch_if u_fetch_if ();

  // memory side
  l0_line_buffer u_line_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch          (u_fetch_if),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (busy_o)
  );

  // core side
  instr_aligner u_aligner (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (req_i),
    .branch_i (branch_i),
    .addr_i   (addr_i),
    .ready_i  (ready_i),
    .valid_o  (valid_o),
    .rdata_o  (rdata_o),
    .addr_o   (addr_o),
    .fetch    (u_fetch_if)
  );

endmodule

/* verification/tb_prefetch_l0.sv */
module tb_prefetch_l0;

  localparam int MEM_HALVES = 2048;
  localparam int TIMEOUT    = 200;

  logic                 clk;
  logic                 rst_n;
  logic                 req_i;
  logic                 branch_i;
  prefetch_pkg::addr_t  addr_i;
  logic                 ready_i;
  logic                 valid_o;
  prefetch_pkg::instr_t rdata_o;
  prefetch_pkg::addr_t  addr_o;
  logic                 instr_req_o;
  prefetch_pkg::addr_t  instr_addr_o;
  logic                 instr_gnt_i;
  logic                 instr_rvalid_i;
  prefetch_pkg::line_t  instr_rdata_i;
  logic                 busy_o;

  prefetch_pkg::half_t  mem [MEM_HALVES];
  int                   errors;
  int                   checks;
  int                   tests;
  int                   ready_pct;

  prefetch_l0_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // memory model and reference
  //////////////////////////////////////////////////////////////////////

  function automatic prefetch_pkg::line_t read_line(input prefetch_pkg::addr_t a);
    prefetch_pkg::line_t l;
    for (int i = 0; i < 8; i++) begin
      l[16*i +: 16] = mem[{a[11:4], i[2:0]}];
    end
    return l;
  endfunction

  // one request at a time and the line is read out at response
  initial begin
    prefetch_pkg::addr_t gnt_addr;
    int                  gnt_delay;
    int                  rv_delay;
    logic                rv_pending;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    gnt_addr       = '0;
    gnt_delay      = 0;
    rv_delay       = 0;
    rv_pending     = 1'b0;
    forever begin
      @(negedge clk);
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (rv_pending) begin
        if (rv_delay == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = read_line(gnt_addr);
          rv_pending     = 1'b0;
        end else begin
          rv_delay--;
        end
      end else if (instr_req_o) begin
        if (gnt_delay == 0) begin
          instr_gnt_i = 1'b1;
          gnt_addr    = instr_addr_o;
          // memory only serves whole lines
          if (instr_addr_o[3:0] !== 4'h0)
            report_error($sformatf("instr_addr_o %h not on a line boundary", instr_addr_o));
          rv_pending  = 1'b1;
          rv_delay    = $urandom_range(3, 0);
          gnt_delay   = $urandom_range(3, 0);
        end else begin
          gnt_delay--;
        end
      end
    end
  end

  // compressed unless the low opcode bits are 11
  function automatic prefetch_pkg::instr_t expected_instr(input prefetch_pkg::addr_t a);
    prefetch_pkg::half_t lo;
    prefetch_pkg::addr_t a_hi;
    lo   = mem[a[11:1]];
    a_hi = a + 32'd2;
    if (lo[1:0] != prefetch_pkg::OPCODE_FULL) return {16'h0000, lo};
    return {mem[a_hi[11:1]], lo};
  endfunction

  task automatic fill_mem_pattern();
    for (int i = 0; i < MEM_HALVES; i++) begin
      mem[i] = 16'(i) ^ 16'h5a50;
    end
  endtask

  // bit i of sizes set means instruction i is 32 bits
  task automatic place_program(input prefetch_pkg::addr_t start, input logic [31:0] sizes,
                               input int n);
    prefetch_pkg::addr_t a;
    prefetch_pkg::addr_t a_hi;
    a = start;
    for (int i = 0; i < n; i++) begin
      a_hi = a + 32'd2;
      mem[a[11:1]] = {a[13:0], sizes[i] ? 2'b11 : 2'b01};
      if (sizes[i]) mem[a_hi[11:1]] = ~a[15:0];
      a = sizes[i] ? a + 32'd4 : a_hi;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // core side driver
  //////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    errors++;
    $display("FAIL t=%0t: %s", $time, msg);
  endtask

  // entered and left on a falling edge
  task automatic run_stream(input prefetch_pkg::addr_t start, input int count);
    prefetch_pkg::addr_t  exp_addr;
    prefetch_pkg::instr_t exp_data;
    prefetch_pkg::instr_t mask;
    prefetch_pkg::addr_t  hold_addr;
    prefetch_pkg::instr_t hold_data;
    logic                 held;
    int                   got;
    int                   idle;
    exp_addr = start;
    held     = 1'b0;
    got      = 0;
    idle     = 0;
    branch_i = 1'b1;
    addr_i   = start;
    req_i    = 1'b1;
    ready_i  = 1'b0;
    #1;
    if (valid_o !== 1'b0) report_error("valid_o high in branch cycle");
    @(negedge clk);
    branch_i = 1'b0;
    while (got < count && idle < TIMEOUT) begin
      if (held && (valid_o !== 1'b1 || addr_o !== hold_addr || rdata_o !== hold_data))
        report_error("outputs moved while ready_i was low");
      ready_i   = ($urandom_range(99, 0) < ready_pct);
      held      = valid_o && !ready_i;
      hold_addr = addr_o;
      hold_data = rdata_o;
      if (valid_o && ready_i) begin
        exp_data = expected_instr(exp_addr);
        mask     = (exp_data[1:0] == prefetch_pkg::OPCODE_FULL) ? 32'hffff_ffff : 32'h0000_ffff;
        checks++;
        if (addr_o !== exp_addr)
          report_error($sformatf("addr_o %h, expected %h", addr_o, exp_addr));
        else if ((rdata_o & mask) !== exp_data)
          report_error($sformatf("rdata_o %h at %h, expected %h", rdata_o, exp_addr, exp_data));
        exp_addr = exp_addr + ((mask[31]) ? 32'd4 : 32'd2);
        got++;
        idle = 0;
      end else begin
        idle++;
      end
      @(negedge clk);
    end
    ready_i = 1'b0;
    if (got < count) begin
      errors++;
      $display("no instruction from the DUT for %0d cycles, stream at %h stalled", TIMEOUT, start);
    end
  endtask

  task automatic wait_busy_level(input logic level);
    int n;
    n = 0;
    while (busy_o !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy_o !== level) begin
      errors++;
      $display("busy_o did not go to %0b in time", level);
    end
  endtask

  task automatic close_test(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors seen");
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic aligned_word_stream();
    int e;
    e = errors;
    if (valid_o !== 1'b0 || instr_req_o !== 1'b0 || busy_o !== 1'b0)
      report_error("valid_o, instr_req_o or busy_o not low after reset");
    fill_mem_pattern();
    place_program(32'h040, 32'hffff_ffff, 16);
    run_stream(32'h040, 12);
    close_test("aligned 32-bit stream", e);
  endtask

  task automatic compressed_stream();
    int e;
    e = errors;
    wait_busy_level(1'b0);
    fill_mem_pattern();
    place_program(32'h102, 32'h0, 24);
    run_stream(32'h102, 20);
    close_test("compressed stream", e);
  endtask

  // 32-bit instructions at offset 14 of several lines
  task automatic crossword_stream();
    int e;
    e = errors;
    wait_busy_level(1'b0);
    fill_mem_pattern();
    place_program(32'h200, 32'h0020_e9fe, 23);
    run_stream(32'h200, 23);
    close_test("mixed crossword stream", e);
  endtask

  task automatic branch_in_flight();
    int e;
    e = errors;
    wait_busy_level(1'b0);
    fill_mem_pattern();
    place_program(32'h100, 32'hffff_ffff, 8);
    place_program(32'h286, 32'h0000_a5f3, 16);
    // stop at word 3 so a prefetch goes out
    run_stream(32'h100, 3);
    wait_busy_level(1'b1);
    run_stream(32'h286, 14);
    close_test("branch with fetch outstanding", e);
  endtask

  task automatic ready_stall_stream();
    int e;
    e = errors;
    wait_busy_level(1'b0);
    fill_mem_pattern();
    place_program(32'h302, $urandom, 32);
    ready_pct = 50;
    run_stream(32'h302, 30);
    ready_pct = 100;
    close_test("random ready stalls", e);
  endtask

  initial begin
    void'($urandom(32'h535a));
    rst_n     = 1'b0;
    req_i     = 1'b0;
    branch_i  = 1'b0;
    addr_i    = '0;
    ready_i   = 1'b0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    ready_pct = 100;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    aligned_word_stream();
    compressed_stream();
    crossword_stream();
    branch_in_flight();
    ready_stall_stream();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
rtl/prefetch_pkg.sv
rtl/line_fetch_if.sv
rtl/l0_line_buffer.sv
rtl/instr_aligner.sv
rtl/prefetch_l0_top.sv
verification/tb_prefetch_l0.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the prefetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_prefetch_l0 \
  -f all.f -o tb_prefetch_l0 \
  && ./obj_dir/tb_prefetch_l0 | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
